/* verilog/spi_pkg.sv */
package spi_pkg;

    localparam int DATA_W = 32;
    localparam int CHAR_W = 8;
    localparam int ADDR_W = 8;

    localparam int SPMODE_EN_BIT = 31;
    localparam int SPIE_DON_BIT  = 0;     // write 1 to clear

    typedef enum logic [ADDR_W-1:0] {
        SPMODE  = 8'h00,
        SPIE    = 8'h04,
        SPCOM   = 8'h08,
        SPITF   = 8'h0C,
        SPIRF   = 8'h10,
        CSMODE0 = 8'h20,
        CSMODE1 = 8'h24,
        CSMODE2 = 8'h28,
        CSMODE3 = 8'h2C
    } reg_addr_e;

    // mode word per chip select
    typedef struct packed {
        logic       cpol;        // sck idle level
        logic [2:0] rsvd_hi;
        logic [3:0] pm;          // half period is pm+1 clocks
        logic [7:0] rsvd_mid;
        logic [3:0] csbef;       // half periods before first edge
        logic [3:0] csaft;       // half periods after last edge
        logic [7:0] rsvd_lo;
    } csmode_t;

    localparam logic [DATA_W-1:0] CSMODE_MASK = 32'h8F00_FF00;

    typedef struct packed {
        logic [1:0]  cs;
        logic [21:0] rsvd;
        logic [7:0]  tranlen;    // characters per frame, 0 acts as 1
    } spcom_t;

    localparam logic [DATA_W-1:0] SPCOM_MASK = 32'hC000_00FF;

    typedef enum logic [2:0] {IDLE, SETUP, CHAR, HOLD, DONE} frame_state_e;

endpackage

/* verilog/spi_ifs.sv */
`timescale 1ns/1ps

// word stream between the register bank and the frame controller
interface word_fifo_if import spi_pkg::*; ();
    logic              push;
    logic [DATA_W-1:0] wdata;
    logic              full;
    logic              pop;
    logic [DATA_W-1:0] rdata;     // head word
    logic              empty;

    modport producer (output push, output wdata, input full);
    modport consumer (output pop, input rdata, input empty);
    modport fifo (input push, input wdata, input pop, output full, output rdata, output empty);
endinterface

// four phase req/ack, one character per cycle of the handshake
interface char_link_if import spi_pkg::*; ();
    logic              req;
    logic              ack;
    logic [CHAR_W-1:0] tx_char;
    logic [CHAR_W-1:0] rx_char;

    modport ctrl (output req, output tx_char, input ack, input rx_char);
    modport shifter (input req, input tx_char, output ack, output rx_char);
endinterface

/* verilog/spi_word_fifo.sv */
`timescale 1ns/1ps

module spi_word_fifo import spi_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input logic       S_SYSCLK,
    input logic       S_RESETN,
    word_fifo_if.fifo f
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              do_push;
    logic              do_pop;

    assign f.full  = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign f.empty = (count == '0);
    assign f.rdata = mem[rd_ptr];

    assign do_push = f.push && !f.full;     // newest word dropped when full
    assign do_pop  = f.pop && !f.empty;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (do_push)
            mem[wr_ptr] <= f.wdata;
    end

endmodule

/* verilog/spi_sck_gen.sv */
`timescale 1ns/1ps

module spi_sck_gen (
    input  logic       S_SYSCLK,
    input  logic       S_RESETN,
    input  logic       run,
    input  logic [3:0] pm,
    output logic       tick
);

    logic [3:0] cnt;
    logic       run_d;    // low for one cycle after run rises

    // one tick every pm+1 clocks
    assign tick = run && run_d && (cnt == '0);

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            cnt   <= '0;
            run_d <= 1'b0;
        end else begin
            run_d <= run;
            if (!run_d || cnt == '0)
                cnt <= pm;          // restart or reload after tick
            else
                cnt <= cnt - 1'b1;
        end
    end

endmodule

/* verilog/spi_char_shifter.sv */
`timescale 1ns/1ps

module spi_char_shifter import spi_pkg::*; (
    input  logic         S_SYSCLK,
    input  logic         S_RESETN,
    input  logic         cpol,
    input  logic         tick,
    char_link_if.shifter link,
    output logic         S_SPI_SCK,
    output logic         S_SPI_MOSI,
    input  logic         S_SPI_MISO
);

    localparam int NEDGE = 2 * CHAR_W;    // half periods per character

    logic                     busy;
    logic                     ack_q;
    logic                     sck_q;
    logic [$clog2(NEDGE)-1:0] edge_cnt;   // even counts are leading edges
    logic [CHAR_W-1:0]        tx_sr;
    logic [CHAR_W-1:0]        rx_sr;

    assign S_SPI_SCK    = sck_q;
    assign S_SPI_MOSI   = tx_sr[CHAR_W-1];    // msb first
    assign link.ack     = ack_q;
    assign link.rx_char = rx_sr;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            busy     <= 1'b0;
            ack_q    <= 1'b0;
            sck_q    <= 1'b0;
            edge_cnt <= '0;
            tx_sr    <= '0;
        end else if (!busy) begin
            sck_q <= cpol;
            if (link.req && !ack_q) begin
                busy     <= 1'b1;
                edge_cnt <= '0;
                tx_sr    <= link.tx_char;   // msb shows before first edge
            end else if (!link.req) begin
                ack_q <= 1'b0;
            end
        end else if (!link.req) begin
            // frame aborted by disable
            busy  <= 1'b0;
            tx_sr <= '0;
        end else if (tick) begin
            sck_q    <= ~sck_q;
            edge_cnt <= edge_cnt + 1'b1;
            if (edge_cnt[0])
                tx_sr <= {tx_sr[CHAR_W-2:0], 1'b0};    // trailing edge
            if (edge_cnt == ($clog2(NEDGE))'(NEDGE - 1)) begin
                busy  <= 1'b0;
                ack_q <= 1'b1;
            end
        end
    end

    // miso sampled on leading edges
    always_ff @(posedge S_SYSCLK) begin
        if (busy && link.req && tick && !edge_cnt[0])
            rx_sr <= {rx_sr[CHAR_W-2:0], S_SPI_MISO};
    end

endmodule

/* verilog/spi_frame_ctrl.sv */
`timescale 1ns/1ps

module spi_frame_ctrl import spi_pkg::*; #(
    parameter int NCS = 4
) (
    input  logic           S_SYSCLK,
    input  logic           S_RESETN,
    input  logic           en,
    input  csmode_t        csmode,
    input  spcom_t         spcom,
    input  logic           start,
    output logic           frame_done,
    word_fifo_if.consumer  tx,
    word_fifo_if.producer  rx,
    char_link_if.ctrl      link,
    input  logic           tick,
    output logic           sck_run,
    output logic [NCS-1:0] spi_sel
);

    frame_state_e      state;
    logic [3:0]        dly_cnt;       // csbef or csaft half periods left
    logic [7:0]        chars_left;
    logic [1:0]        byte_idx;      // 0 is byte 3 of the word
    logic              have_word;
    logic              req_q;
    logic [DATA_W-1:0] tx_word;
    logic [DATA_W-1:0] rx_word;
    logic [DATA_W-1:0] rx_next;
    logic              need_word;
    logic              char_done;
    logic              word_end;

    assign link.req     = req_q;
    assign link.tx_char = tx_word[DATA_W-1 -: CHAR_W];
    assign sck_run      = (state == SETUP) || (state == CHAR) || (state == HOLD);
    assign frame_done   = (state == DONE);

    assign need_word = (state == CHAR) && !have_word && !req_q && !link.ack;
    assign char_done = (state == CHAR) && req_q && link.ack;
    assign word_end  = (byte_idx == 2'd3) || (chars_left == 8'd1);

    assign tx.pop   = en && need_word && !tx.empty;   // waits here on empty
    assign rx.push  = en && char_done && word_end;
    assign rx.wdata = rx_next;

    // received byte merged top down
    always_comb begin
        rx_next = rx_word;
        rx_next[DATA_W-1 - CHAR_W*byte_idx -: CHAR_W] = link.rx_char;
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state      <= IDLE;
            spi_sel    <= '1;
            dly_cnt    <= '0;
            chars_left <= '0;
            byte_idx   <= '0;
            have_word  <= 1'b0;
            req_q      <= 1'b0;
        end else if (!en) begin
            state   <= IDLE;
            spi_sel <= '1;
            req_q   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= SETUP;
                        spi_sel    <= ~(NCS'(1) << spcom.cs);
                        dly_cnt    <= csmode.csbef;
                        chars_left <= (spcom.tranlen == '0) ? 8'd1 : spcom.tranlen;
                        byte_idx   <= '0;
                        have_word  <= 1'b0;
                    end
                end
                SETUP: begin
                    if (dly_cnt == '0)
                        state <= CHAR;
                    else if (tick)
                        dly_cnt <= dly_cnt - 1'b1;
                end
                CHAR: begin
                    if (tx.pop) begin
                        have_word <= 1'b1;
                    end else if (have_word && !req_q && !link.ack) begin
                        req_q <= 1'b1;
                    end else if (char_done) begin
                        req_q      <= 1'b0;
                        byte_idx   <= byte_idx + 1'b1;
                        chars_left <= chars_left - 1'b1;
                        if (byte_idx == 2'd3)
                            have_word <= 1'b0;
                        if (chars_left == 8'd1) begin
                            state   <= HOLD;
                            dly_cnt <= csmode.csaft;
                        end
                    end
                end
                HOLD: begin
                    if (dly_cnt == '0) begin
                        state   <= DONE;
                        spi_sel <= '1;
                    end else if (tick) begin
                        dly_cnt <= dly_cnt - 1'b1;
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // word registers
    always_ff @(posedge S_SYSCLK) begin
        if (tx.pop)
            tx_word <= tx.rdata;
        else if (char_done)
            tx_word <= tx_word << CHAR_W;   // next byte to the top
        if (start && state == IDLE)
            rx_word <= '0;
        else if (char_done)
            rx_word <= word_end ? '0 : rx_next;
    end

endmodule

/* verilog/spi_reg_bank.sv */
`timescale 1ns/1ps

module spi_reg_bank import spi_pkg::*; #(
    parameter int NCS = 4
) (
    input  logic                S_SYSCLK,
    input  logic                S_RESETN,
    input  logic [ADDR_W-1:0]   S_AWADDR,
    input  logic [DATA_W-1:0]   S_WDATA,
    input  logic [DATA_W/8-1:0] S_WSTRB,
    input  logic                S_AWVALID,
    input  logic                S_WVALID,
    input  logic                S_BREADY,
    input  logic [ADDR_W-1:0]   S_ARADDR,
    input  logic                S_ARVALID,
    input  logic                S_RREADY,
    output logic                S_AWREADY,
    output logic                S_WREADY,
    output logic                S_BVALID,
    output logic [1:0]          S_BRESP,
    output logic                S_ARREADY,
    output logic [DATA_W-1:0]   S_RDATA,
    output logic [1:0]          S_RRESP,
    output logic                S_RVALID,
    word_fifo_if.producer       tx,
    word_fifo_if.consumer       rx,
    output logic                en,
    output csmode_t             csmode,
    output spcom_t              spcom,
    output logic                start,
    input  logic                frame_done
);

    logic              aw_rdy;
    logic              ar_rdy;
    logic              wr_en;
    logic              rd_en;
    logic              done_q;     // sticky frame done
    logic              busy;       // frame in flight
    logic              spcom_wr;
    logic [DATA_W-1:0] rd_data;
    spcom_t            spcom_q;
    csmode_t           csmode_q [NCS];

    assign S_AWREADY = aw_rdy;
    assign S_WREADY  = aw_rdy;
    assign S_BRESP   = 2'b00;
    assign S_ARREADY = ar_rdy;
    assign S_RRESP   = 2'b00;

    assign wr_en    = aw_rdy && S_AWVALID && S_WVALID;
    assign rd_en    = ar_rdy && S_ARVALID;
    assign spcom_wr = wr_en && (S_AWADDR == SPCOM) && !busy;   // ignored while busy

    assign tx.push  = wr_en && (S_AWADDR == SPITF);
    assign tx.wdata = S_WDATA;
    assign rx.pop   = rd_en && (S_ARADDR == SPIRF);

    assign spcom  = spcom_q;
    assign csmode = (int'(spcom_q.cs) < NCS) ? csmode_q[spcom_q.cs] : '0;

    // byte strobes applied, reserved bits cleared
    function automatic logic [DATA_W-1:0] wr_merge(input logic [DATA_W-1:0] cur,
                                                   input logic [DATA_W-1:0] mask);
        logic [DATA_W-1:0] res;
        res = cur;
        for (int b = 0; b < DATA_W/8; b++) begin
            if (S_WSTRB[b])
                res[8*b +: 8] = S_WDATA[8*b +: 8];
        end
        return res & mask;
    endfunction

    // bus handshakes, one transaction per channel at a time
    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            aw_rdy   <= 1'b0;
            ar_rdy   <= 1'b0;
            S_BVALID <= 1'b0;
            S_RVALID <= 1'b0;
            S_RDATA  <= '0;
        end else begin
            aw_rdy <= S_AWVALID && S_WVALID && !aw_rdy && !S_BVALID;
            ar_rdy <= S_ARVALID && !ar_rdy && !S_RVALID;
            if (wr_en)
                S_BVALID <= 1'b1;
            else if (S_BREADY)
                S_BVALID <= 1'b0;
            if (rd_en) begin
                S_RVALID <= 1'b1;
                S_RDATA  <= rd_data;
            end else if (S_RREADY) begin
                S_RVALID <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            en      <= 1'b0;
            done_q  <= 1'b0;
            busy    <= 1'b0;
            start   <= 1'b0;
            spcom_q <= '0;
            for (int i = 0; i < NCS; i++)
                csmode_q[i] <= '0;
        end else begin
            start <= spcom_wr && en;
            if (spcom_wr && en)
                busy <= 1'b1;
            else if (frame_done || !en)
                busy <= 1'b0;
            if (frame_done)
                done_q <= 1'b1;
            else if (wr_en && S_AWADDR == SPIE && S_WSTRB[SPIE_DON_BIT/8]
                     && S_WDATA[SPIE_DON_BIT])
                done_q <= 1'b0;
            if (wr_en) begin
                case (S_AWADDR)
                    SPMODE: begin
                        if (S_WSTRB[SPMODE_EN_BIT/8])
                            en <= S_WDATA[SPMODE_EN_BIT];
                    end
                    SPCOM: begin
                        if (!busy)
                            spcom_q <= wr_merge(spcom_q, SPCOM_MASK);
                    end
                    CSMODE0, CSMODE1, CSMODE2, CSMODE3: begin
                        if (int'(S_AWADDR[3:2]) < NCS)
                            csmode_q[S_AWADDR[3:2]] <= wr_merge(csmode_q[S_AWADDR[3:2]],
                                                                CSMODE_MASK);
                    end
                    default: ;
                endcase
            end
        end
    end

    // read mux, sampled into S_RDATA on the address handshake
    always_comb begin
        rd_data = '0;
        case (S_ARADDR)
            SPMODE: rd_data[SPMODE_EN_BIT] = en;
            SPIE:   rd_data[SPIE_DON_BIT] = done_q;
            SPCOM:  rd_data = spcom_q;
            SPIRF:  rd_data = rx.empty ? '0 : rx.rdata;   // empty reads zero
            CSMODE0, CSMODE1, CSMODE2, CSMODE3: begin
                if (int'(S_ARADDR[3:2]) < NCS)
                    rd_data = csmode_q[S_ARADDR[3:2]];
            end
            default: ;
        endcase
    end

endmodule

/* verilog/spi_top.sv */
`timescale 1ns/1ps

module spi_top import spi_pkg::*; #(
    parameter int NCS        = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                S_SYSCLK,
    input  logic                S_RESETN,
    input  logic [ADDR_W-1:0]   S_AWADDR,
    input  logic [DATA_W-1:0]   S_WDATA,
    input  logic [DATA_W/8-1:0] S_WSTRB,
    input  logic                S_AWVALID,
    input  logic                S_WVALID,
    input  logic                S_BREADY,
    input  logic [ADDR_W-1:0]   S_ARADDR,
    input  logic                S_ARVALID,
    input  logic                S_RREADY,
    output logic                S_AWREADY,
    output logic                S_WREADY,
    output logic                S_BVALID,
    output logic [1:0]          S_BRESP,
    output logic                S_ARREADY,
    output logic [DATA_W-1:0]   S_RDATA,
    output logic [1:0]          S_RRESP,
    output logic                S_RVALID,
    input  logic                S_SPI_MISO,
    output logic                S_SPI_SCK,
    output logic                S_SPI_MOSI,
    output logic [NCS-1:0]      S_SPI_SEL
);

    logic    en;
    csmode_t csmode;       // mode of the selected chip select
    spcom_t  spcom;
    logic    start;
    logic    frame_done;
    logic    sck_run;
    logic    tick;

    word_fifo_if tx_fifo ();
    word_fifo_if rx_fifo ();
    char_link_if link ();

    spi_reg_bank #(.NCS(NCS)) u_reg_bank (
        .*,
        .tx (tx_fifo),
        .rx (rx_fifo)
    );

    spi_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .S_SYSCLK,
        .S_RESETN,
        .f (tx_fifo)
    );

    spi_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .S_SYSCLK,
        .S_RESETN,
        .f (rx_fifo)
    );

    spi_frame_ctrl #(.NCS(NCS)) u_frame_ctrl (
        .*,
        .tx      (tx_fifo),
        .rx      (rx_fifo),
        .spi_sel (S_SPI_SEL)
    );

    spi_sck_gen u_sck_gen (
        .*,
        .run (sck_run),
        .pm  (csmode.pm)
    );

    spi_char_shifter u_shifter (
        .*,
        .cpol (csmode.cpol)
    );

endmodule

/* test/tb_spi_slave.sv */
`timescale 1ns/1ps

module tb_spi_slave #(
    parameter int NCS = 4
) (
    input  logic           sck,
    input  logic           mosi,
    input  logic [NCS-1:0] sel,
    input  logic [63:0]    miso_bits,    // first bit sent at the top
    output logic           miso
);

    logic           armed;
    logic           idle_lvl;            // sck level seen at select fall
    logic [NCS-1:0] sel_seen;
    logic           sck_at_fall;
    logic           sck_at_rise;
    logic [7:0]     mosi_sr;
    logic [7:0]     mosi_bytes [16];
    int             nbits;
    int             nbytes;
    int             miso_idx;
    wire            active = ~&sel;

    initial begin
        armed       = 1'b0;
        idle_lvl    = 1'b0;
        sel_seen    = '1;
        sck_at_fall = 1'b0;
        sck_at_rise = 1'b0;
        mosi_sr     = '0;
        nbits       = 0;
        nbytes      = 0;
        miso_idx    = 0;
        miso        = 1'b0;
    end

    // sck may move to the new cpol on the same edge as the select
    always @(posedge active) begin
        #1;
        sel_seen    = sel;
        sck_at_fall = sck;
        idle_lvl    = sck;
        nbits       = 0;
        nbytes      = 0;
        miso_idx    = 0;
        miso        = miso_bits[63];
        armed       = 1'b1;
    end

    always @(negedge active) begin
        armed = 1'b0;
        #1;
        sck_at_rise = sck;
    end

    always @(sck) begin
        if (armed && sck != idle_lvl) begin
            // leading edge, capture mosi
            mosi_sr = {mosi_sr[6:0], mosi};
            nbits++;
            if (nbits % 8 == 0 && nbytes < 16) begin
                mosi_bytes[nbytes] = mosi_sr;
                nbytes++;
            end
        end else if (armed) begin
            miso_idx++;     // trailing edge, next bit out
            miso = (miso_idx < 64) ? miso_bits[63 - miso_idx] : 1'b0;
        end
    end

endmodule

/* test/tb_spi_top.sv */
`timescale 1ns/1ps

module tb_spi_top import spi_pkg::*; ();

    localparam int NCS        = 4;
    localparam int FIFO_DEPTH = 4;

    typedef struct packed {
        logic [1:0]  cs;
        logic        cpol;
        logic [3:0]  pm;
        logic [3:0]  csbef;
        logic [3:0]  csaft;
        logic [7:0]  tranlen;
        logic        mrnd;        // miso bytes from the lcg
        logic [31:0] tx0;
        logic [31:0] tx1;
        logic [31:0] miso0;
        logic [31:0] miso1;
    } pat_t;

    logic                S_SYSCLK;
    logic                S_RESETN;
    logic [ADDR_W-1:0]   S_AWADDR;
    logic [DATA_W-1:0]   S_WDATA;
    logic [DATA_W/8-1:0] S_WSTRB;
    logic                S_AWVALID;
    logic                S_WVALID;
    logic                S_BREADY;
    logic [ADDR_W-1:0]   S_ARADDR;
    logic                S_ARVALID;
    logic                S_RREADY;
    logic                S_AWREADY;
    logic                S_WREADY;
    logic                S_BVALID;
    logic [1:0]          S_BRESP;
    logic                S_ARREADY;
    logic [DATA_W-1:0]   S_RDATA;
    logic [1:0]          S_RRESP;
    logic                S_RVALID;
    logic                S_SPI_MISO;
    logic                S_SPI_SCK;
    logic                S_SPI_MOSI;
    logic [NCS-1:0]      S_SPI_SEL;
    logic [63:0]         slave_miso;

    pat_t        pats [$];
    int          limit_clks = 0;
    logic [31:0] rng_state = 32'hfdb9cd5b;

    spi_top #(.NCS(NCS), .FIFO_DEPTH(FIFO_DEPTH)) DUT (.*);

    tb_spi_slave #(.NCS(NCS)) slave_model (
        .sck       (S_SPI_SCK),
        .mosi      (S_SPI_MOSI),
        .sel       (S_SPI_SEL),
        .miso_bits (slave_miso),
        .miso      (S_SPI_MISO)
    );

    always #10 S_SYSCLK = ~S_SYSCLK;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [ADDR_W-1:0] csmode_addr(input logic [1:0] cs);
        return 8'h20 + {4'h0, cs, 2'b00};
    endfunction

    // only the addressed select is low
    function automatic logic [NCS-1:0] sel_for_cs(input logic [1:0] cs);
        logic [NCS-1:0] v;
        for (int b = 0; b < NCS; b++)
            v[b] = (b != int'(cs));
        return v;
    endfunction

    function automatic csmode_t clear_reserved(input logic [DATA_W-1:0] v);
        csmode_t c;
        c = csmode_t'(v);
        c.rsvd_hi  = '0;
        c.rsvd_mid = '0;
        c.rsvd_lo  = '0;
        return c;
    endfunction

    function automatic logic [DATA_W-1:0] apply_strobe(input logic [DATA_W-1:0] old,
                                                       input logic [DATA_W-1:0] nw,
                                                       input logic [3:0] strb);
        logic [DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
            if (strb[b])
                res[8*b +: 8] = nw[8*b +: 8];
        return res;
    endfunction

    // serial time of one frame plus select delays and bus overhead
    function automatic int pattern_clocks(input pat_t p);
        int len;
        len = (p.tranlen == 0) ? 1 : int'(p.tranlen);
        return (len * 16 + 32) * (int'(p.pm) + 1) + 800;
    endfunction

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic abort_with(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %08h actual %08h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_sel(input string name, input logic [NCS-1:0] exp,
                             input logic [NCS-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_csmode(input string name, input csmode_t exp, input csmode_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %08h actual %08h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [3:0] strb);
        int n;
        @(negedge S_SYSCLK);
        S_AWADDR  = addr;
        S_WDATA   = data;
        S_WSTRB   = strb;
        S_AWVALID = 1'b1;
        S_WVALID  = 1'b1;
        n = 0;
        @(negedge S_SYSCLK);
        while (!S_AWREADY) begin
            n++;
            if (n > 20)
                abort_with("write address was never accepted");
            @(negedge S_SYSCLK);
        end
        check_word("write data ready", 32'h1, 32'(S_WREADY));
        @(negedge S_SYSCLK);    // handshake on the edge before
        S_AWVALID = 1'b0;
        S_WVALID  = 1'b0;
        if (!S_BVALID)
            abort_with("no write response after the handshake");
        check_word("write response", 32'h0, 32'(S_BRESP));
        S_BREADY = 1'b1;
        @(negedge S_SYSCLK);
        S_BREADY = 1'b0;
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int n;
        @(negedge S_SYSCLK);
        S_ARADDR  = addr;
        S_ARVALID = 1'b1;
        n = 0;
        @(negedge S_SYSCLK);
        while (!S_ARREADY) begin
            n++;
            if (n > 20)
                abort_with("read address was never accepted");
            @(negedge S_SYSCLK);
        end
        @(negedge S_SYSCLK);
        S_ARVALID = 1'b0;
        if (!S_RVALID)
            abort_with("no read data after the handshake");
        data = S_RDATA;
        check_word("read response", 32'h0, 32'(S_RRESP));
        S_RREADY = 1'b1;
        @(negedge S_SYSCLK);
        S_RREADY = 1'b0;
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        int          cs, cpol, pm, bef, aft, len, rnd;
        logic [31:0] t0, t1, m0, m1;
        pat_t        p;
        fd = $fopen("test/spi_patterns.txt", "r");
        if (fd == 0)
            abort_with("cannot open test/spi_patterns.txt");
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                        cs, cpol, pm, bef, aft, len, rnd, t0, t1, m0, m1);
            if (n != 11)
                abort_with("malformed line in the pattern file");
            p = '{cs: 2'(cs), cpol: 1'(cpol), pm: 4'(pm), csbef: 4'(bef), csaft: 4'(aft),
                  tranlen: 8'(len), mrnd: 1'(rnd), tx0: t0, tx1: t1, miso0: m0, miso1: m1};
            pats.push_back(p);
        end
        $fclose(fd);
    endtask

    task automatic test_csmode_strobes();
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] rd;
        logic [3:0]        strb_tab [4];
        csmode_t           exp;
        strb_tab = '{4'b0101, 4'b1010, 4'b1000, 4'b0011};
        for (int i = 0; i < NCS; i++) begin
            d = next_rand();
            bus_write(csmode_addr(2'(i)), d, 4'hF);
            exp = clear_reserved(d);
            bus_read(csmode_addr(2'(i)), rd);
            check_csmode($sformatf("csmode%0d full write", i), exp, csmode_t'(rd));
            d = next_rand();
            bus_write(csmode_addr(2'(i)), d, strb_tab[i]);
            exp = clear_reserved(apply_strobe(exp, d, strb_tab[i]));
            bus_read(csmode_addr(2'(i)), rd);
            check_csmode($sformatf("csmode%0d strobed write", i), exp, csmode_t'(rd));
        end
    endtask

    task automatic run_pattern(input int idx);
        pat_t              p;
        int                len;
        int                nwords;
        csmode_t           c;
        spcom_t            s;
        logic [63:0]       miso;
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] exp;
        string             name;
        p      = pats[idx];
        len    = (p.tranlen == 0) ? 1 : int'(p.tranlen);   // zero length acts as one
        nwords = (len + 3) / 4;
        name   = $sformatf("pattern %0d", idx);
        c = '0;
        c.cpol  = p.cpol;
        c.pm    = p.pm;
        c.csbef = p.csbef;
        c.csaft = p.csaft;
        bus_write(csmode_addr(p.cs), c, 4'hF);
        bus_read(csmode_addr(p.cs), rd);
        check_csmode({name, " csmode"}, c, csmode_t'(rd));
        miso = p.mrnd ? {next_rand(), next_rand()} : {p.miso0, p.miso1};
        slave_miso = miso;
        bus_write(SPITF, p.tx0, 4'hF);
        if (nwords > 1)
            bus_write(SPITF, p.tx1, 4'hF);
        s = '0;
        s.cs      = p.cs;
        s.tranlen = p.tranlen;
        bus_write(SPCOM, s, 4'hF);
        rd = '0;
        while (!rd[SPIE_DON_BIT])
            bus_read(SPIE, rd);
        check_sel({name, " sel after done"}, '1, S_SPI_SEL);
        check_sel({name, " sel in frame"}, sel_for_cs(p.cs), slave_model.sel_seen);
        check_word({name, " sck at sel fall"}, 32'(p.cpol), 32'(slave_model.sck_at_fall));
        check_word({name, " sck at sel rise"}, 32'(p.cpol), 32'(slave_model.sck_at_rise));
        check_word({name, " mosi byte count"}, 32'(len), 32'(slave_model.nbytes));
        for (int k = 0; k < len; k++) begin
            exp = (k < 4) ? p.tx0 : p.tx1;      // byte 3 goes first
            check_word($sformatf("%s mosi byte %0d", name, k), 32'(exp[31 - 8*(k%4) -: 8]),
                       32'(slave_model.mosi_bytes[k]));
        end
        for (int w = 0; w < nwords; w++) begin
            exp = '0;
            for (int j = 0; j < 4; j++)
                if (4*w + j < len)
                    exp[31 - 8*j -: 8] = miso[63 - 32*w - 8*j -: 8];
            bus_read(SPIRF, rd);
            check_word($sformatf("%s rx word %0d", name, w), exp, rd);
        end
        bus_read(SPIRF, rd);
        check_word({name, " rx fifo empty"}, 32'h0, rd);
        bus_write(SPIE, 32'h1, 4'h1);
        bus_read(SPIE, rd);
        check_word({name, " done cleared"}, 32'h0, rd);
    endtask

    initial begin
        logic [DATA_W-1:0] rd;
        spcom_t            s;
        S_SYSCLK   = 1'b0;
        S_RESETN   = 1'b0;
        S_AWADDR   = '0;
        S_WDATA    = '0;
        S_WSTRB    = '0;
        S_AWVALID  = 1'b0;
        S_WVALID   = 1'b0;
        S_BREADY   = 1'b0;
        S_ARADDR   = '0;
        S_ARVALID  = 1'b0;
        S_RREADY   = 1'b0;
        slave_miso = '0;
        load_patterns();
        limit_clks = 3000;
        foreach (pats[i])
            limit_clks += pattern_clocks(pats[i]);
        repeat (2) @(posedge S_SYSCLK);
        @(negedge S_SYSCLK);
        S_RESETN = 1'b1;
        check_sel("reset sel", '1, S_SPI_SEL);
        check_word("reset outputs", 32'h0, 32'({S_AWREADY, S_WREADY, S_BVALID, S_ARREADY,
                                                 S_RVALID, S_SPI_SCK, S_SPI_MOSI}));
        test_csmode_strobes();
        bus_write(SPMODE, 32'h8000_0000, 4'h8);
        foreach (pats[i])
            run_pattern(i);
        // start request with the controller disabled
        bus_write(SPMODE, 32'h0, 4'h8);
        s = '0;
        s.cs      = 2'd1;
        s.tranlen = 8'd2;
        bus_write(SPCOM, s, 4'hF);
        repeat (50) begin
            @(negedge S_SYSCLK);
            check_sel("sel while disabled", '1, S_SPI_SEL);
        end
        bus_read(SPIE, rd);
        check_word("done while disabled", 32'h0, rd);
        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        wait (limit_clks > 0);
        repeat (limit_clks) @(posedge S_SYSCLK);
        $display("timeout, the run took more than %0d clocks", limit_clks);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* test/spi_patterns.txt */
# cs cpol pm csbef csaft tranlen mrnd tx0 tx1 miso0 miso1, all hex
# mrnd 1 takes the miso bytes from the lcg and ignores the miso columns
0 0 1 2 2 04 0 A5C30F81 00000000 3C5A96E1 00000000
1 1 2 1 3 06 0 11223344 55667788 DEADBEEF CAFEF00D
2 0 0 0 0 08 1 0F1E2D3C 4B5A6978 00000000 00000000
3 1 3 4 1 01 0 80000000 00000000 7E000000 00000000
0 1 0 3 0 03 1 C0FFEE00 00000000 00000000 00000000
1 0 2 0 2 00 0 5A000000 00000000 81000000 00000000
2 1 1 1 1 05 0 01020304 05060708 F0E1D2C3 B4A59687
3 0 4 2 2 07 1 FEDCBA98 76543210 00000000 00000000

/* build.f */
verilog/spi_pkg.sv
verilog/spi_ifs.sv
verilog/spi_word_fifo.sv
verilog/spi_sck_gen.sv
verilog/spi_char_shifter.sv
verilog/spi_frame_ctrl.sv
verilog/spi_reg_bank.sv
verilog/spi_top.sv
test/tb_spi_slave.sv
test/tb_spi_top.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator and run; exit status is the simulation result
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_spi_top -f build.f -o tb_spi_top
./obj_dir/tb_spi_top
